/* bench/alu_testdata.txt */
# in:  valid thr op a b offset a_wait b_wait a_tkt b_tkt dest pc  wr_en wr_thr wr_tkt wr_data  flush
# out: stall wb_valid wb_thr wb_dest wb_data wb_write wb_ovf take_br br_thr br_pc (after next edge)
0 0 0 0 0 0 0 0 0 0 0 0  0 0 0 0  0  0 0 0 0 0 0 0 0 0 0
1 0 0 5 3 0 0 0 0 0 1 100  0 0 0 0  0  0 0 0 0 0 0 0 0 0 0
1 1 1 a 3 0 0 0 0 0 2 104  0 0 0 0  0  0 1 0 1 8 1 0 0 0 0
1 2 2 10 ff 20 0 1 0 0 3 108  0 0 0 0  0  0 1 1 2 7 1 0 0 0 0
1 3 3 30 0 10 0 0 0 0 4 10c  0 0 0 0  0  0 1 2 3 30 1 0 0 0 0
1 0 4 3 0 4 0 0 0 0 5 110  0 0 0 0  0  0 1 3 4 20 1 0 0 0 0
1 1 5 80 0 3 0 0 0 0 6 114  0 0 0 0  0  0 1 0 5 30 1 0 0 0 0
1 2 0 ffffffff 1 0 0 0 0 0 7 118  0 0 0 0  0  0 1 1 6 10 1 0 0 0 0
1 3 2 fffffff0 0 20 0 0 0 0 8 11c  0 0 0 0  0  0 1 2 0 0 0 1 0 0 0
1 0 4 80000000 0 1 0 0 0 0 9 120  0 0 0 0  0  0 1 3 0 0 0 1 0 0 0
1 1 3 5 0 6 0 0 0 0 a 124  0 0 0 0  0  0 1 0 0 0 0 1 0 0 0
1 0 6 7 7 400 0 0 0 0 0 128  0 0 0 0  0  0 1 1 0 0 0 1 0 0 0
1 1 6 7 8 404 0 0 0 0 0 12c  0 0 0 0  0  0 1 0 0 0 0 0 1 0 400
1 2 7 1 2 408 0 0 0 0 0 130  0 0 0 0  0  0 1 1 0 0 0 0 0 0 0
1 3 7 3 3 40c 0 0 0 0 0 134  0 0 0 0  0  0 1 2 0 0 0 0 1 2 408
1 0 8 1 ffffffff 410 0 0 0 0 0 138  0 0 0 0  0  0 1 3 0 0 0 0 0 0 0
1 1 8 ffffffff 1 414 0 0 0 0 0 13c  0 0 0 0  0  0 1 0 0 0 0 0 1 0 410
1 2 9 5 5 418 0 0 0 0 0 140  0 0 0 0  0  0 1 1 0 0 0 0 0 0 0
1 3 9 4 5 41c 0 0 0 0 0 144  0 0 0 0  0  0 1 2 0 0 0 0 1 2 418
1 0 a 0 0 beef 0 0 0 0 0 148  0 0 0 0  0  0 1 3 0 0 0 0 0 0 0
1 1 0 0 11 0 1 0 5 0 b 14c  0 0 0 0  0  2 1 0 0 0 0 0 1 0 beef
0 0 0 0 0 0 0 0 0 0 0 0  1 2 5 100  0  2 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0  1 1 6 200  0  2 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0  1 1 5 300  0  0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0  0 0 0 0  0  0 1 1 b 311 1 0 0 0 0
1 2 1 50 0 0 0 1 0 9 c 150  1 2 9 10  0  0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0  0 0 0 0  0  0 1 2 c 40 1 0 0 0 0
1 3 0 1000 0 0 0 1 0 2a d 154  0 0 0 0  0  8 0 0 0 0 0 0 0 0 0
1 0 0 1 2 0 0 0 0 0 e 158  1 3 2a 234  0  8 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0  0 0 0 0  0  0 1 0 e 3 1 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0  0 0 0 0  0  0 1 3 d 1234 1 0 0 0 0
1 2 1 0 1 0 1 0 7 0 f 15c  0 0 0 0  0  4 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0  0 0 0 0  4  0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0  1 2 7 55  0  0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0  0 0 0 0  0  0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0  0 0 0 0  0  0 0 0 0 0 0 0 0 0 0

/* build.f */
verilog/alu_pkg.sv
verilog/alu_interfaces.sv
verilog/alu_dispatch.sv
verilog/thread_slot.sv
verilog/alu_execute.sv
verilog/alu_stage.sv
bench/tb_clock.sv
bench/alu_stage_checker.sv
bench/alu_stage_tb.sv

/* Makefile */
TOP = alu_stage_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) +verilator+error+limit+100 > sim.log 2>&1 || true
	cat sim.log
	grep -q "^all tests passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

/* bench/alu_stage_tb.sv */
`timescale 1ns/1ps

module alu_stage_tb
    import alu_pkg::*;
();

    localparam int THREADS        = DEFAULT_THREADS;
    localparam int DATA_WIDTH     = DEFAULT_DATA_WIDTH;
    localparam int TICKET_WIDTH   = DEFAULT_TICKET_WIDTH;
    localparam int PC_WIDTH       = DEFAULT_PC_WIDTH;
    localparam int OFFSET_WIDTH   = DEFAULT_OFFSET_WIDTH;
    localparam int REG_ADDR_WIDTH = DEFAULT_REG_ADDR_WIDTH;
    localparam int THREAD_WIDTH   = (THREADS > 1) ? $clog2(THREADS) : 1;
    localparam int RESET_CYCLES   = 4;
    localparam int OPEN_TRIES     = 3;
    localparam int MAX_CYCLES     = 100;
    localparam int FIELDS         = 27;

    logic                      clock;
    logic                      reset;
    logic                      req_valid;
    logic [THREAD_WIDTH-1:0]   req_thread;
    alu_op_t                   req_op;
    logic [DATA_WIDTH-1:0]     req_a;
    logic [DATA_WIDTH-1:0]     req_b;
    logic [OFFSET_WIDTH-1:0]   req_offset;
    logic                      req_a_wait;
    logic                      req_b_wait;
    logic [TICKET_WIDTH-1:0]   req_a_ticket;
    logic [TICKET_WIDTH-1:0]   req_b_ticket;
    logic [REG_ADDR_WIDTH-1:0] req_dest;
    logic [PC_WIDTH-1:0]       req_pc;
    logic                      wr_en;
    logic [THREAD_WIDTH-1:0]   wr_thread;
    logic [TICKET_WIDTH-1:0]   wr_ticket;
    logic [DATA_WIDTH-1:0]     wr_data;
    logic [THREADS-1:0]        flush;
    logic [THREADS-1:0]        stall_decode;
    logic                      wb_valid;
    logic [THREAD_WIDTH-1:0]   wb_thread;
    logic [REG_ADDR_WIDTH-1:0] wb_dest;
    logic [DATA_WIDTH-1:0]     wb_data;
    logic                      wb_write;
    logic                      wb_overflow;
    logic                      take_branch;
    logic [THREAD_WIDTH-1:0]   branch_thread;
    logic [PC_WIDTH-1:0]       branch_pc;

    // Expected outputs of the current data line
    logic [3:0]                op_field;
    logic [THREADS-1:0]        exp_stall;
    logic                      exp_wb_valid;
    logic [THREAD_WIDTH-1:0]   exp_wb_thread;
    logic [REG_ADDR_WIDTH-1:0] exp_wb_dest;
    logic [DATA_WIDTH-1:0]     exp_wb_data;
    logic                      exp_wb_write;
    logic                      exp_wb_overflow;
    logic                      exp_take_branch;
    logic [THREAD_WIDTH-1:0]   exp_branch_thread;
    logic [PC_WIDTH-1:0]       exp_branch_pc;

    int fd;
    int line_no;

    tb_clock #(.HALF_PERIOD(50)) i_clock (.clock(clock));

    alu_stage #(
        .THREADS(THREADS), .DATA_WIDTH(DATA_WIDTH), .TICKET_WIDTH(TICKET_WIDTH),
        .PC_WIDTH(PC_WIDTH), .OFFSET_WIDTH(OFFSET_WIDTH), .REG_ADDR_WIDTH(REG_ADDR_WIDTH)
    ) i_dut (.*);

    //////////////////////////////////////////////////////////////////////
    // Reporting
    //////////////////////////////////////////////////////////////////////

    task automatic stop_on_error(input string text);
        $display("%s", text);
        $display("tests failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string what, input logic [63:0] actual,
                               input logic [63:0] expected);
        string text;
        if (actual !== expected)
        begin
            text = $sformatf("FAIL at time %0t: %s is %0h, expected %0h (data line %0d)",
                             $time, what, actual, expected, line_no);
            stop_on_error(text);
        end
    endtask

    task automatic clear_inputs();
        req_valid    = 1'b0;
        req_thread   = '0;
        req_op       = OP_ADD;
        req_a        = '0;
        req_b        = '0;
        req_offset   = '0;
        req_a_wait   = 1'b0;
        req_b_wait   = 1'b0;
        req_a_ticket = '0;
        req_b_ticket = '0;
        req_dest     = '0;
        req_pc       = '0;
        wr_en        = 1'b0;
        wr_thread    = '0;
        wr_ticket    = '0;
        wr_data      = '0;
        flush        = '0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test data
    //////////////////////////////////////////////////////////////////////

    // Drives the next data line onto the inputs, skipping comments and blanks
    task automatic read_vector(output bit found);
        string text;
        int    fields;
        found = 1'b0;
        while (!found && !$feof(fd))
        begin
            text = "";
            if ($fgets(text, fd) != 0 && text.len() > 0 && text[0] != "#")
            begin
                fields = $sscanf(text,
                "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    req_valid, req_thread, op_field, req_a, req_b, req_offset,
                    req_a_wait, req_b_wait, req_a_ticket, req_b_ticket, req_dest, req_pc,
                    wr_en, wr_thread, wr_ticket, wr_data, flush,
                    exp_stall, exp_wb_valid, exp_wb_thread, exp_wb_dest, exp_wb_data,
                    exp_wb_write, exp_wb_overflow, exp_take_branch, exp_branch_thread,
                    exp_branch_pc);
                if (fields == FIELDS)
                begin
                    req_op = alu_op_t'(op_field);
                    line_no++;
                    found = 1'b1;
                end
                else if (fields > 0)
                    stop_on_error($sformatf("test data line after vector %0d is malformed",
                                            line_no));
            end
        end
    endtask

    task automatic check_outputs();
        check_value("stall_decode", 64'(stall_decode), 64'(exp_stall));
        check_value("wb_valid", 64'(wb_valid), 64'(exp_wb_valid));
        check_value("wb_write", 64'(wb_write), 64'(exp_wb_write));
        check_value("wb_overflow", 64'(wb_overflow), 64'(exp_wb_overflow));
        check_value("take_branch", 64'(take_branch), 64'(exp_take_branch));
        if (exp_wb_valid)
            check_value("wb_thread", 64'(wb_thread), 64'(exp_wb_thread));
        if (exp_wb_write)
        begin
            check_value("wb_dest", 64'(wb_dest), 64'(exp_wb_dest));
            check_value("wb_data", 64'(wb_data), 64'(exp_wb_data));
        end
        if (exp_take_branch)
        begin
            check_value("branch_thread", 64'(branch_thread), 64'(exp_branch_thread));
            check_value("branch_pc", 64'(branch_pc), 64'(exp_branch_pc));
        end
        check_value("assertion failures", 64'(i_dut.i_checker.failure_count), 64'd0);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////////

    initial
    begin
        int attempts;
        int cycles;
        bit found;
        clear_inputs();
        reset   = 1'b1;
        line_no = 0;
        repeat (RESET_CYCLES)
            @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        check_value("wb_valid after reset", 64'(wb_valid), 64'd0);
        check_value("take_branch after reset", 64'(take_branch), 64'd0);
        check_value("stall_decode after reset", 64'(stall_decode), 64'd0);

        fd       = 0;
        attempts = 0;
        while (fd == 0 && attempts < OPEN_TRIES)
        begin
            fd = $fopen("bench/alu_testdata.txt", "r");
            attempts++;
            if (fd == 0)
                @(negedge clock);
        end
        if (fd == 0)
            stop_on_error("could not open the test data file bench/alu_testdata.txt");

        // One data line per cycle, inputs on the falling edge
        cycles = 0;
        read_vector(found);
        while (found)
        begin
            @(negedge clock);
            check_outputs();
            cycles++;
            if (cycles >= MAX_CYCLES)
                stop_on_error($sformatf("test data did not end within %0d cycles",
                                        MAX_CYCLES));
            read_vector(found);
        end
        $fclose(fd);

        if (line_no == 0)
            stop_on_error("the test data file holds no test vectors");
        else
        begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule

/* bench/alu_stage_checker.sv */
`timescale 1ns/1ps

module alu_stage_checker
#(
    parameter int THREADS = 4
)
(
    input logic               clock,
    input logic               reset,
    input logic [THREADS-1:0] grant,
    input logic [THREADS-1:0] load,
    input logic [THREADS-1:0] stall,
    input logic               wb_valid,
    input logic               take_branch
);

    // Read by the testbench every cycle
    int failure_count = 0;

    // At most one slot wins the execute unit
    grant_one_hot : assert property (@(posedge clock) disable iff (reset) $onehot0(grant))
    else
    begin
        failure_count++;
        $error("more than one slot granted");
    end

    // Decode must hold off a stalled thread
    no_load_when_stalled : assert property (@(posedge clock) disable iff (reset)
        (load & stall) == '0)
    else
    begin
        failure_count++;
        $error("request loaded into a stalled thread");
    end

    branch_needs_valid : assert property (@(posedge clock) disable iff (reset)
        take_branch |-> wb_valid)
    else
    begin
        failure_count++;
        $error("branch taken without a valid result");
    end

endmodule

bind alu_stage alu_stage_checker #(.THREADS(THREADS)) i_checker (
    .clock       (clock),
    .reset       (reset),
    .grant       (i_execute.grant_vec),
    .load        (issue.load),
    .stall       (stall_decode),
    .wb_valid    (wb_valid),
    .take_branch (take_branch)
);

/* bench/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock
#(
    parameter int HALF_PERIOD = 50
)
(
    output logic clock
);

    // Free running, period of two half periods
    initial
    begin
        clock = 1'b0;
        forever
            #(HALF_PERIOD) clock = ~clock;
    end

endmodule

/* verilog/alu_stage.sv */
`timescale 1ns/1ps

module alu_stage
    import alu_pkg::*;
#(
    parameter int THREADS        = DEFAULT_THREADS,
    parameter int DATA_WIDTH     = DEFAULT_DATA_WIDTH,
    parameter int TICKET_WIDTH   = DEFAULT_TICKET_WIDTH,
    parameter int PC_WIDTH       = DEFAULT_PC_WIDTH,
    parameter int OFFSET_WIDTH   = DEFAULT_OFFSET_WIDTH,
    parameter int REG_ADDR_WIDTH = DEFAULT_REG_ADDR_WIDTH,
    localparam int THREAD_WIDTH  = (THREADS > 1) ? $clog2(THREADS) : 1
)
(
    input  logic                      clock,
    input  logic                      reset,

    // Request from decode
    input  logic                      req_valid,
    input  logic [THREAD_WIDTH-1:0]   req_thread,
    input  alu_op_t                   req_op,
    input  logic [DATA_WIDTH-1:0]     req_a,
    input  logic [DATA_WIDTH-1:0]     req_b,
    input  logic [OFFSET_WIDTH-1:0]   req_offset,
    input  logic                      req_a_wait,
    input  logic                      req_b_wait,
    input  logic [TICKET_WIDTH-1:0]   req_a_ticket,
    input  logic [TICKET_WIDTH-1:0]   req_b_ticket,
    input  logic [REG_ADDR_WIDTH-1:0] req_dest,
    input  logic [PC_WIDTH-1:0]       req_pc,

    // Register file write broadcast
    input  logic                      wr_en,
    input  logic [THREAD_WIDTH-1:0]   wr_thread,
    input  logic [TICKET_WIDTH-1:0]   wr_ticket,
    input  logic [DATA_WIDTH-1:0]     wr_data,

    input  logic [THREADS-1:0]        flush,
    output logic [THREADS-1:0]        stall_decode,

    // To writeback
    output logic                      wb_valid,
    output logic [THREAD_WIDTH-1:0]   wb_thread,
    output logic [REG_ADDR_WIDTH-1:0] wb_dest,
    output logic [DATA_WIDTH-1:0]     wb_data,
    output logic                      wb_write,
    output logic                      wb_overflow,

    // To fetch
    output logic                      take_branch,
    output logic [THREAD_WIDTH-1:0]   branch_thread,
    output logic [PC_WIDTH-1:0]       branch_pc
);

    issue_if #(
        .THREADS(THREADS), .DATA_WIDTH(DATA_WIDTH), .TICKET_WIDTH(TICKET_WIDTH),
        .PC_WIDTH(PC_WIDTH), .OFFSET_WIDTH(OFFSET_WIDTH), .REG_ADDR_WIDTH(REG_ADDR_WIDTH)
    ) issue ();

    wake_if #(
        .THREADS(THREADS), .TICKET_WIDTH(TICKET_WIDTH), .DATA_WIDTH(DATA_WIDTH)
    ) wake ();

    slot_if #(
        .DATA_WIDTH(DATA_WIDTH), .PC_WIDTH(PC_WIDTH),
        .OFFSET_WIDTH(OFFSET_WIDTH), .REG_ADDR_WIDTH(REG_ADDR_WIDTH)
    ) slot_bus [THREADS] ();

    assign wake.en     = wr_en;
    assign wake.thread = wr_thread;
    assign wake.ticket = wr_ticket;
    assign wake.data   = wr_data;

    alu_dispatch #(
        .THREADS(THREADS), .DATA_WIDTH(DATA_WIDTH), .TICKET_WIDTH(TICKET_WIDTH),
        .PC_WIDTH(PC_WIDTH), .OFFSET_WIDTH(OFFSET_WIDTH), .REG_ADDR_WIDTH(REG_ADDR_WIDTH)
    ) i_dispatch (
        .req_valid    (req_valid),
        .req_thread   (req_thread),
        .req_op       (req_op),
        .req_a        (req_a),
        .req_b        (req_b),
        .req_offset   (req_offset),
        .req_a_wait   (req_a_wait),
        .req_b_wait   (req_b_wait),
        .req_a_ticket (req_a_ticket),
        .req_b_ticket (req_b_ticket),
        .req_dest     (req_dest),
        .req_pc       (req_pc),
        .iss          (issue)
    );

    // One slot per hardware thread
    for (genvar t = 0; t < THREADS; t++)
    begin : g_slot
        thread_slot #(
            .THREAD_INDEX(t), .THREADS(THREADS), .DATA_WIDTH(DATA_WIDTH),
            .TICKET_WIDTH(TICKET_WIDTH), .PC_WIDTH(PC_WIDTH),
            .OFFSET_WIDTH(OFFSET_WIDTH), .REG_ADDR_WIDTH(REG_ADDR_WIDTH)
        ) i_slot (
            .clock        (clock),
            .reset        (reset),
            .flush_thread (flush[t]),
            .iss          (issue),
            .wk           (wake),
            .sl           (slot_bus[t]),
            .stall        (stall_decode[t])
        );
    end

    alu_execute #(
        .THREADS(THREADS), .DATA_WIDTH(DATA_WIDTH), .PC_WIDTH(PC_WIDTH),
        .OFFSET_WIDTH(OFFSET_WIDTH), .REG_ADDR_WIDTH(REG_ADDR_WIDTH)
    ) i_execute (
        .clock         (clock),
        .reset         (reset),
        .slots         (slot_bus),
        .wb_valid      (wb_valid),
        .wb_thread     (wb_thread),
        .wb_dest       (wb_dest),
        .wb_data       (wb_data),
        .wb_write      (wb_write),
        .wb_overflow   (wb_overflow),
        .take_branch   (take_branch),
        .branch_thread (branch_thread),
        .branch_pc     (branch_pc)
    );

endmodule

/* verilog/alu_execute.sv */
`timescale 1ns/1ps

module alu_execute
    import alu_pkg::*;
#(
    parameter int THREADS        = DEFAULT_THREADS,
    parameter int DATA_WIDTH     = DEFAULT_DATA_WIDTH,
    parameter int PC_WIDTH       = DEFAULT_PC_WIDTH,
    parameter int OFFSET_WIDTH   = DEFAULT_OFFSET_WIDTH,
    parameter int REG_ADDR_WIDTH = DEFAULT_REG_ADDR_WIDTH,
    localparam int THREAD_WIDTH  = (THREADS > 1) ? $clog2(THREADS) : 1
)
(
    input  logic                      clock,
    input  logic                      reset,

    slot_if.execute                   slots [THREADS],

    output logic                      wb_valid,
    output logic [THREAD_WIDTH-1:0]   wb_thread,
    output logic [REG_ADDR_WIDTH-1:0] wb_dest,
    output logic [DATA_WIDTH-1:0]     wb_data,
    output logic                      wb_write,
    output logic                      wb_overflow,

    output logic                      take_branch,
    output logic [THREAD_WIDTH-1:0]   branch_thread,
    output logic [PC_WIDTH-1:0]       branch_pc
);

    localparam int WIDE = 2 * DATA_WIDTH;

    logic [THREADS-1:0]        ready_vec;
    logic [THREADS-1:0]        grant_vec;
    alu_op_t                   op_vec     [THREADS];
    op_class_t                 cls_vec    [THREADS];
    logic [DATA_WIDTH-1:0]     a_vec      [THREADS];
    logic [DATA_WIDTH-1:0]     b_vec      [THREADS];
    logic [REG_ADDR_WIDTH-1:0] dest_vec   [THREADS];
    logic [OFFSET_WIDTH-1:0]   offset_vec [THREADS];

    logic                      any_ready;
    logic [THREAD_WIDTH-1:0]   sel;
    logic [DATA_WIDTH-1:0]     a_sel;
    logic [DATA_WIDTH-1:0]     b_sel;
    logic [WIDE-1:0]           wide;
    logic                      overflow;
    logic                      cond;

    for (genvar t = 0; t < THREADS; t++)
    begin : g_gather
        assign ready_vec[t]  = slots[t].ready;
        assign op_vec[t]     = slots[t].op;
        assign cls_vec[t]    = slots[t].cls;
        assign a_vec[t]      = slots[t].a_data;
        assign b_vec[t]      = slots[t].b_data;
        assign dest_vec[t]   = slots[t].dest;
        assign offset_vec[t] = slots[t].offset;
        assign slots[t].grant = grant_vec[t];
    end

    //////////////////////////////////////////////////////////////////////
    // Fixed priority, lowest thread first
    //////////////////////////////////////////////////////////////////////

    assign grant_vec = ready_vec & (~ready_vec + THREADS'(1));
    assign any_ready = |ready_vec;

    always_comb
    begin
        sel = '0;
        for (int t = THREADS - 1; t >= 0; t--)
        begin
            if (ready_vec[t])
                sel = THREAD_WIDTH'(t);
        end
    end

    assign a_sel = a_vec[sel];
    assign b_sel = b_vec[sel];

    // Double width result so carries out show up above DATA_WIDTH
    always_comb
    begin
        wide     = '0;
        overflow = 1'b0;
        cond     = 1'b0;
        case (op_vec[sel])
            OP_ADD, OP_ADDI:
            begin
                wide     = WIDE'(a_sel) + WIDE'(b_sel);
                overflow = |wide[WIDE-1:DATA_WIDTH];
            end
            OP_SUB:
                wide = WIDE'(a_sel) - WIDE'(b_sel);
            OP_SUBI:
            begin
                wide     = WIDE'(a_sel) - WIDE'(b_sel);
                overflow = b_sel > a_sel;
            end
            OP_SLL:
            begin
                wide     = WIDE'(a_sel) << b_sel;
                // Shifts past the wide result lose every bit
                overflow = |wide[WIDE-1:DATA_WIDTH] || (a_sel != '0 && wide == '0);
            end
            OP_SRL:
                wide = WIDE'(a_sel) >> b_sel;
            OP_BEQ:  cond = a_sel == b_sel;
            OP_BNE:  cond = a_sel != b_sel;
            OP_BLT:  cond = a_sel < b_sel;
            OP_BGE:  cond = a_sel >= b_sel;
            OP_JUMP: cond = 1'b1;
            default: wide = '0;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Registered outputs to writeback and fetch
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            wb_valid    <= 1'b0;
            wb_write    <= 1'b0;
            wb_overflow <= 1'b0;
            take_branch <= 1'b0;
        end
        else
        begin
            wb_valid    <= any_ready;
            wb_write    <= any_ready && cls_vec[sel] == CLASS_ARITH && !overflow;
            wb_overflow <= any_ready && cls_vec[sel] == CLASS_ARITH && overflow;
            take_branch <= any_ready && cond
                           && (cls_vec[sel] == CLASS_BRANCH || cls_vec[sel] == CLASS_JUMP);
        end
    end

    always_ff @(posedge clock)
    begin
        if (any_ready)
        begin
            wb_thread     <= sel;
            wb_dest       <= dest_vec[sel];
            wb_data       <= wide[DATA_WIDTH-1:0];
            branch_thread <= sel;
            branch_pc     <= PC_WIDTH'(offset_vec[sel]);
        end
    end

endmodule

/* verilog/thread_slot.sv */
`timescale 1ns/1ps

module thread_slot
    import alu_pkg::*;
#(
    parameter int THREAD_INDEX   = 0,
    parameter int THREADS        = DEFAULT_THREADS,
    parameter int DATA_WIDTH     = DEFAULT_DATA_WIDTH,
    parameter int TICKET_WIDTH   = DEFAULT_TICKET_WIDTH,
    parameter int PC_WIDTH       = DEFAULT_PC_WIDTH,
    parameter int OFFSET_WIDTH   = DEFAULT_OFFSET_WIDTH,
    parameter int REG_ADDR_WIDTH = DEFAULT_REG_ADDR_WIDTH,
    localparam int THREAD_WIDTH  = (THREADS > 1) ? $clog2(THREADS) : 1
)
(
    input  logic clock,
    input  logic reset,
    input  logic flush_thread,

    issue_if.slot iss,
    wake_if.slot  wk,
    slot_if.slot  sl,

    output logic  stall
);

    logic                      occupied;
    logic                      a_wait;
    logic                      b_wait;
    logic [TICKET_WIDTH-1:0]   a_ticket;
    logic [TICKET_WIDTH-1:0]   b_ticket;
    logic [DATA_WIDTH-1:0]     a_data;
    logic [DATA_WIDTH-1:0]     b_data;
    alu_op_t                   op;
    op_class_t                 cls;
    logic [REG_ADDR_WIDTH-1:0] dest;
    logic [PC_WIDTH-1:0]       pc;
    logic [OFFSET_WIDTH-1:0]   offset;

    logic load;
    logic wake_thread;
    logic a_hit_new;
    logic b_hit_new;
    logic a_hit_held;
    logic b_hit_held;

    assign load        = iss.load[THREAD_INDEX];
    assign wake_thread = wk.en && wk.thread == THREAD_WIDTH'(THREAD_INDEX);

    // Broadcast matching the request arriving right now
    assign a_hit_new   = wake_thread && iss.a_wait && wk.ticket == iss.a_ticket;
    assign b_hit_new   = wake_thread && iss.b_wait && wk.ticket == iss.b_ticket;

    // Broadcast matching what is already held
    assign a_hit_held  = wake_thread && a_wait && wk.ticket == a_ticket;
    assign b_hit_held  = wake_thread && b_wait && wk.ticket == b_ticket;

    //////////////////////////////////////////////////////////////////////
    // Occupancy and wait flags
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock)
    begin
        if (reset || flush_thread)
        begin
            occupied <= 1'b0;
            a_wait   <= 1'b0;
            b_wait   <= 1'b0;
        end
        else if (load)
        begin
            occupied <= 1'b1;
            a_wait   <= iss.a_wait && !a_hit_new;
            b_wait   <= iss.b_wait && !b_hit_new;
        end
        else
        begin
            if (sl.grant)
                occupied <= 1'b0;
            if (a_hit_held)
                a_wait <= 1'b0;
            if (b_hit_held)
                b_wait <= 1'b0;
        end
    end

    // Held instruction and operands
    always_ff @(posedge clock)
    begin
        if (load)
        begin
            op       <= iss.op;
            cls      <= iss.cls;
            dest     <= iss.dest;
            pc       <= iss.pc;
            offset   <= iss.offset;
            a_ticket <= iss.a_ticket;
            b_ticket <= iss.b_ticket;
            a_data   <= a_hit_new ? wk.data : iss.a_data;
            b_data   <= b_hit_new ? wk.data : iss.b_data;
        end
        else
        begin
            if (a_hit_held)
                a_data <= wk.data;
            if (b_hit_held)
                b_data <= wk.data;
        end
    end

    assign sl.ready  = occupied && !a_wait && !b_wait;
    assign sl.op     = op;
    assign sl.cls    = cls;
    assign sl.a_data = a_data;
    assign sl.b_data = b_data;
    assign sl.dest   = dest;
    assign sl.pc     = pc;
    assign sl.offset = offset;

    // Decode may refill the slot in the cycle it is granted
    assign stall = occupied && !sl.grant;

endmodule

/* verilog/alu_dispatch.sv */
`timescale 1ns/1ps

module alu_dispatch
    import alu_pkg::*;
#(
    parameter int THREADS        = DEFAULT_THREADS,
    parameter int DATA_WIDTH     = DEFAULT_DATA_WIDTH,
    parameter int TICKET_WIDTH   = DEFAULT_TICKET_WIDTH,
    parameter int PC_WIDTH       = DEFAULT_PC_WIDTH,
    parameter int OFFSET_WIDTH   = DEFAULT_OFFSET_WIDTH,
    parameter int REG_ADDR_WIDTH = DEFAULT_REG_ADDR_WIDTH,
    localparam int THREAD_WIDTH  = (THREADS > 1) ? $clog2(THREADS) : 1
)
(
    input  logic                      req_valid,
    input  logic [THREAD_WIDTH-1:0]   req_thread,
    input  alu_op_t                   req_op,
    input  logic [DATA_WIDTH-1:0]     req_a,
    input  logic [DATA_WIDTH-1:0]     req_b,
    input  logic [OFFSET_WIDTH-1:0]   req_offset,
    input  logic                      req_a_wait,
    input  logic                      req_b_wait,
    input  logic [TICKET_WIDTH-1:0]   req_a_ticket,
    input  logic [TICKET_WIDTH-1:0]   req_b_ticket,
    input  logic [REG_ADDR_WIDTH-1:0] req_dest,
    input  logic [PC_WIDTH-1:0]       req_pc,

    issue_if.dispatch                 iss
);

    op_class_t cls;
    logic      imm_form;

    // Opcode decode
    always_comb
    begin
        cls      = CLASS_NONE;
        imm_form = 1'b0;
        case (req_op)
            OP_ADD, OP_SUB:
                cls = CLASS_ARITH;
            OP_ADDI, OP_SUBI, OP_SLL, OP_SRL:
            begin
                cls      = CLASS_ARITH;
                imm_form = 1'b1;
            end
            OP_BEQ, OP_BNE, OP_BLT, OP_BGE:
                cls = CLASS_BRANCH;
            OP_JUMP:
                cls = CLASS_JUMP;
            default:
                cls = CLASS_NONE;
        endcase
    end

    // Illegal opcodes never reach a slot
    assign iss.load = (req_valid && cls != CLASS_NONE) ? THREADS'(1) << req_thread : '0;

    assign iss.op       = req_op;
    assign iss.cls      = cls;
    assign iss.a_data   = req_a;
    assign iss.a_wait   = req_a_wait;
    assign iss.a_ticket = req_a_ticket;

    // Immediate forms take the offset as second operand, nothing to wait for
    assign iss.b_data   = imm_form ? DATA_WIDTH'(req_offset) : req_b;
    assign iss.b_wait   = req_b_wait && !imm_form;
    assign iss.b_ticket = req_b_ticket;

    assign iss.dest     = req_dest;
    assign iss.pc       = req_pc;
    assign iss.offset   = req_offset;

endmodule

/* verilog/alu_interfaces.sv */
`timescale 1ns/1ps

// Decoded request from dispatch, seen by every thread slot
interface issue_if
    import alu_pkg::*;
#(
    parameter int THREADS        = DEFAULT_THREADS,
    parameter int DATA_WIDTH     = DEFAULT_DATA_WIDTH,
    parameter int TICKET_WIDTH   = DEFAULT_TICKET_WIDTH,
    parameter int PC_WIDTH       = DEFAULT_PC_WIDTH,
    parameter int OFFSET_WIDTH   = DEFAULT_OFFSET_WIDTH,
    parameter int REG_ADDR_WIDTH = DEFAULT_REG_ADDR_WIDTH
) ();
    logic [THREADS-1:0]        load;
    alu_op_t                   op;
    op_class_t                 cls;
    logic [DATA_WIDTH-1:0]     a_data;
    logic [DATA_WIDTH-1:0]     b_data;
    logic                      a_wait;
    logic                      b_wait;
    logic [TICKET_WIDTH-1:0]   a_ticket;
    logic [TICKET_WIDTH-1:0]   b_ticket;
    logic [REG_ADDR_WIDTH-1:0] dest;
    logic [PC_WIDTH-1:0]       pc;
    logic [OFFSET_WIDTH-1:0]   offset;

    modport dispatch (output load, op, cls, a_data, b_data, a_wait, b_wait,
                      a_ticket, b_ticket, dest, pc, offset);
    modport slot     (input  load, op, cls, a_data, b_data, a_wait, b_wait,
                      a_ticket, b_ticket, dest, pc, offset);
endinterface

// Register file write broadcast
interface wake_if
    import alu_pkg::*;
#(
    parameter int THREADS      = DEFAULT_THREADS,
    parameter int TICKET_WIDTH = DEFAULT_TICKET_WIDTH,
    parameter int DATA_WIDTH   = DEFAULT_DATA_WIDTH
) ();
    localparam int THREAD_WIDTH = (THREADS > 1) ? $clog2(THREADS) : 1;

    logic                    en;
    logic [THREAD_WIDTH-1:0] thread;
    logic [TICKET_WIDTH-1:0] ticket;
    logic [DATA_WIDTH-1:0]   data;

    modport slot (input en, thread, ticket, data);
endinterface

// One pending instruction, offered by its slot to the execute unit
interface slot_if
    import alu_pkg::*;
#(
    parameter int DATA_WIDTH     = DEFAULT_DATA_WIDTH,
    parameter int PC_WIDTH       = DEFAULT_PC_WIDTH,
    parameter int OFFSET_WIDTH   = DEFAULT_OFFSET_WIDTH,
    parameter int REG_ADDR_WIDTH = DEFAULT_REG_ADDR_WIDTH
) ();
    logic                      ready;
    logic                      grant;
    alu_op_t                   op;
    op_class_t                 cls;
    logic [DATA_WIDTH-1:0]     a_data;
    logic [DATA_WIDTH-1:0]     b_data;
    logic [REG_ADDR_WIDTH-1:0] dest;
    logic [PC_WIDTH-1:0]       pc;
    logic [OFFSET_WIDTH-1:0]   offset;

    modport slot    (output ready, op, cls, a_data, b_data, dest, pc, offset,
                     input  grant);
    modport execute (input  ready, op, cls, a_data, b_data, dest, pc, offset,
                     output grant);
endinterface

/* verilog/alu_pkg.sv */
package alu_pkg;

    //////////////////////////////////////////////////////////////////////
    // Opcodes seen by the execute stage
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [3:0]
    {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_ADDI = 4'd2,
        OP_SUBI = 4'd3,
        OP_SLL  = 4'd4,
        OP_SRL  = 4'd5,
        OP_BEQ  = 4'd6,
        OP_BNE  = 4'd7,
        OP_BLT  = 4'd8,
        OP_BGE  = 4'd9,
        OP_JUMP = 4'd10
    } alu_op_t;

    // Kind of work, decided once at dispatch
    typedef enum logic [1:0]
    {
        CLASS_NONE   = 2'd0,
        CLASS_ARITH  = 2'd1,
        CLASS_BRANCH = 2'd2,
        CLASS_JUMP   = 2'd3
    } op_class_t;

    //////////////////////////////////////////////////////////////////////
    // Default sizes for the module parameters
    //////////////////////////////////////////////////////////////////////

    localparam int DEFAULT_THREADS        = 4;
    localparam int DEFAULT_DATA_WIDTH     = 32;
    localparam int DEFAULT_TICKET_WIDTH   = 6;
    localparam int DEFAULT_PC_WIDTH       = 32;
    localparam int DEFAULT_OFFSET_WIDTH   = 16;
    localparam int DEFAULT_REG_ADDR_WIDTH = 5;

endpackage
